//--- bench/snes_mem_tb.sv
////////////////////////////////////////////////////////////////////////////
// testbench for the SNES memory request front end, checks by assertions
// stimulus walks loader, rom, wram, priority, bsram and lane steering
////////////////////////////////////////////////////////////////////////////

`include "snes_mem_macros.svh"

module snes_mem_tb;

    localparam int SEED      = 32'hbe2eb9f3;
    localparam int LOAD_LEN  = 90;   // rough cycle budget per test
    localparam int ROM_LEN   = 60;
    localparam int WRAM_LEN  = 40;
    localparam int PRIO_LEN  = 10;
    localparam int BSRAM_LEN = 40;
    localparam int LANE_LEN  = 30;
    localparam int TIMEOUT   = LOAD_LEN + ROM_LEN + WRAM_LEN + PRIO_LEN + BSRAM_LEN
                               + LANE_LEN + 130;

    logic wclk = 1'b0;
    logic resetn;
    logic sdram_busy, loader_fail, frame_pause, sysclkf_ce, sysclkr_ce;
    logic loading, load_valid, rom_ce_n, rom_word;
    logic wram_ce_n, wram_rd_n, wram_we_n, bsram_ce_n, bsram_rd_n, bsram_we_n;
    logic aram_ce_n, aram_oe_n, aram_we_n;
    snes_mem_pkg::mem_byte_t  load_data, wram_d, rom_type, bsram_d, aram_d;
    snes_mem_pkg::snes_addr_t rom_addr;
    snes_mem_pkg::snes_addr_t exp_addr;   // byte address the loader should hit
    snes_mem_pkg::mem_word_t  cpu_port0, cpu_port1, aram_dout;
    logic [`WRAM_ADDR_W-1:0]  wram_addr;
    logic [`BSRAM_ADDR_W-1:0] bsram_addr_in;
    logic [`ARAM_ADDR_W-1:0]  aram_addr;

    logic [`SNES_ADDR_W-2:0]  cpu_word_addr;
    snes_mem_pkg::mem_word_t  cpu_din, rom_q, aram_din;
    logic [1:0]               cpu_ds;
    logic cpu_port, cpu_rd, cpu_wr, bsram_rd, bsram_wr, aram_rd, aram_wr;
    logic [`BSRAM_ADDR_W-1:0] bsram_addr;
    snes_mem_pkg::mem_byte_t  bsram_din, wram_q, aram_q;

    // reference state, built from the front end rules
    logic run_m, f2_m, r2_m, lsb_m;
    logic [40:0] want_load, want_wram;    // {word addr, ds, din}
    logic [22:0] want_rom;
    logic [29:0] want_bsram;              // {rd, wr, addr, data}
    logic load_hit, rom_hit, wram_any, wram_rd_hit, wram_wr_hit, idle;
    snes_mem_pkg::snes_addr_t wram_full;
    snes_mem_pkg::req_src_e   exp_src;

    // read return lanes, a byte shift picks the wanted byte
    logic [31:0]              rom_pair;   // port0 twice, shift by 8 swaps
    snes_mem_pkg::mem_word_t  exp_rom_q;
    snes_mem_pkg::mem_byte_t  exp_wram_q;
    logic [25:0]              exp_aram;   // {aram_q, aram_din, aram_rd, aram_wr}

    string test_name = "reset";
    int errors = 0;
    int err_mark = 0;
    int tests_ok = 0;
    int tests_bad = 0;
    int cycles = 0;

    snes_mem_top u_dut (.*);

    always #4 wclk = ~wclk;

    always @(posedge wclk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT) begin
            $display("timeout, run still busy after %0d cycles", TIMEOUT);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    assign wram_full = {`WRAM_BANK_TAG, wram_addr};
    assign load_hit  = loading && load_valid;
    assign rom_hit   = !load_hit && !rom_ce_n && f2_m;
    assign wram_any  = !wram_ce_n && (!wram_rd_n || !wram_we_n);
    assign wram_rd_hit = !load_hit && !rom_hit && !wram_ce_n && !wram_rd_n && f2_m;
    assign wram_wr_hit = !load_hit && !rom_hit && !wram_ce_n && !wram_we_n && r2_m;
    assign idle      = !load_hit && !rom_hit && !wram_any;
    assign exp_src   = load_hit ? snes_mem_pkg::src_load :
                       rom_hit  ? snes_mem_pkg::src_rom  :
                       wram_any ? snes_mem_pkg::src_wram : snes_mem_pkg::src_none;

    // odd byte access brings the high lane down to the low byte
    assign rom_pair   = {cpu_port0, cpu_port0};
    assign exp_rom_q  = 16'(rom_pair >> {!rom_word && rom_addr[0], 3'b000});
    assign exp_wram_q = 8'(cpu_port1 >> {wram_addr[0], 3'b000});
    assign exp_aram   = {8'(aram_dout >> {lsb_m, 3'b000}), aram_d, aram_d,
                         !aram_ce_n && !aram_oe_n, !aram_ce_n && !aram_we_n};

    always @(posedge wclk) begin
        if (!resetn) begin
            run_m      <= 1'b0;
            f2_m       <= 1'b0;
            r2_m       <= 1'b0;
            lsb_m      <= 1'b0;
            want_load  <= '0;
            want_wram  <= '0;
            want_rom   <= '0;
            want_bsram <= '0;
        end else begin
            run_m     <= !sdram_busy && !loader_fail && !frame_pause;
            f2_m      <= sysclkf_ce && run_m;
            r2_m      <= sysclkr_ce && run_m;
            want_load <= {exp_addr[23:1], exp_addr[0], ~exp_addr[0], load_data, load_data};
            want_wram <= {wram_full[23:1], wram_addr[0], ~wram_addr[0], wram_d, wram_d};
            want_rom  <= rom_addr[23:1];
            want_bsram <= {!bsram_ce_n && f2_m &&
                               (!bsram_rd_n || rom_type[7:4] == `ROM_TYPE_BSRD),
                           !bsram_ce_n && !bsram_we_n && r2_m, bsram_addr_in, bsram_d};
            if (!aram_ce_n && !aram_oe_n)
                lsb_m <= aram_addr[0];   // lane of the last aram read
        end
    end

    task automatic report_value(input string what, input logic [63:0] exp,
                                input logic [63:0] act);
        errors = errors + 1;
        $display("** Error %s (%s): expected %h actual %h", test_name, what, exp, act);
    endtask

    task automatic report_event(input string msg);
        errors = errors + 1;
        $display("%s: %s", test_name, msg);
    endtask

    // sampled on the falling edge, between drive and capture
    a_load : assert property (@(negedge wclk) disable iff (!resetn)
        $past(exp_src == snes_mem_pkg::src_load) |->
            (cpu_wr && !cpu_port && {cpu_word_addr, cpu_ds, cpu_din} == want_load))
        else report_value("loader write", {1'b1, want_load},
                          {cpu_wr, cpu_word_addr, cpu_ds, cpu_din});
    a_rom : assert property (@(negedge wclk) disable iff (!resetn)
        $past(rom_hit) |-> (cpu_rd && !cpu_port && {cpu_word_addr, cpu_ds} == {want_rom, 2'b11}))
        else report_value("rom read", {1'b1, want_rom, 2'b11}, {cpu_rd, cpu_word_addr, cpu_ds});
    a_wram_rd : assert property (@(negedge wclk) disable iff (!resetn)
        $past(wram_rd_hit) |-> (cpu_rd && cpu_port
                                && {cpu_word_addr, cpu_ds} == want_wram[40:16]))
        else report_value("wram read", {1'b1, want_wram[40:16]},
                          {cpu_rd, cpu_word_addr, cpu_ds});
    a_wram_wr : assert property (@(negedge wclk) disable iff (!resetn)
        $past(wram_wr_hit) |-> (cpu_wr && cpu_port
                                && {cpu_word_addr, cpu_ds, cpu_din} == want_wram))
        else report_value("wram write", {1'b1, want_wram},
                          {cpu_wr, cpu_word_addr, cpu_ds, cpu_din});
    a_no_stray_rd : assert property (@(negedge wclk) disable iff (!resetn)
        cpu_rd |-> $past(rom_hit || wram_rd_hit))
        else report_event("cpu_rd without a gated rom or wram read the cycle before");
    a_no_stray_wr : assert property (@(negedge wclk) disable iff (!resetn)
        cpu_wr |-> $past(load_hit || wram_wr_hit))
        else report_event("cpu_wr without a loader byte or rise phase write");
    a_idle : assert property (@(negedge wclk) disable iff (!resetn)
        $past(idle) |-> ({cpu_word_addr, cpu_ds, cpu_din, cpu_port, cpu_rd, cpu_wr} == '0))
        else report_value("idle port", 64'h0,
                          {cpu_word_addr, cpu_ds, cpu_din, cpu_port, cpu_rd, cpu_wr});
    a_bsram : assert property (@(negedge wclk) disable iff (!resetn)
        {bsram_rd, bsram_wr, bsram_addr, bsram_din} == want_bsram)
        else report_value("bsram", want_bsram, {bsram_rd, bsram_wr, bsram_addr, bsram_din});
    a_rom_q : assert property (@(negedge wclk) disable iff (!resetn)
        rom_q == exp_rom_q)
        else report_value("rom_q", exp_rom_q, rom_q);
    a_wram_q : assert property (@(negedge wclk) disable iff (!resetn)
        wram_q == exp_wram_q)
        else report_value("wram_q", exp_wram_q, wram_q);
    a_aram : assert property (@(negedge wclk) disable iff (!resetn)
        {aram_q, aram_din, aram_rd, aram_wr} == exp_aram)
        else report_value("aram", exp_aram, {aram_q, aram_din, aram_rd, aram_wr});

    task automatic step;
        @(posedge wclk);
        #1;
    endtask

    // one core phase pulse, then let the request drain
    task automatic phase_pulse(input logic fall);
        if (fall)
            sysclkf_ce = 1'b1;
        else
            sysclkr_ce = 1'b1;
        step;
        sysclkf_ce = 1'b0;
        sysclkr_ce = 1'b0;
        step;
        step;
    endtask

    task automatic send_bytes(input int n);
        repeat (n) begin
            load_valid = 1'b1;
            load_data  = 8'($urandom);
            step;
            load_valid = 1'b0;
            exp_addr   = exp_addr + 24'd1;
            repeat ($urandom % 3) step;   // random gap
        end
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        err_mark  = errors;
    endtask

    task automatic end_test;
        step;
        step;
        if (errors == err_mark) begin
            tests_ok = tests_ok + 1;
            $display("test %s: ok", test_name);
        end else begin
            tests_bad = tests_bad + 1;
            $display("test %s: %0d errors", test_name, errors - err_mark);
        end
    endtask

    initial begin
        void'($urandom(SEED));
        resetn = 1'b0;
        {sdram_busy, loader_fail, frame_pause, sysclkf_ce, sysclkr_ce} = '0;
        {loading, load_valid, rom_word} = '0;
        {rom_ce_n, wram_ce_n, wram_rd_n, wram_we_n} = '1;
        {bsram_ce_n, bsram_rd_n, bsram_we_n, aram_ce_n, aram_oe_n, aram_we_n} = '1;
        {load_data, wram_d, rom_type, bsram_d, aram_d} = '0;
        {rom_addr, exp_addr, cpu_port0, cpu_port1, aram_dout} = '0;
        {wram_addr, bsram_addr_in, aram_addr} = '0;
        repeat (3) @(posedge wclk);
        #1 resetn = 1'b1;
        step;

        begin_test("loader");
        loading  = 1'b1;
        exp_addr = '0;
        step;                 // rise cycle, counter restarts
        send_bytes(20);
        loading = 1'b0;
        step;
        loading  = 1'b1;      // second load starts at 0 again
        exp_addr = '0;
        step;
        send_bytes(5);
        loading = 1'b0;
        end_test;

        begin_test("rom read");
        rom_ce_n = 1'b0;
        repeat (6) begin
            rom_addr = snes_mem_pkg::snes_addr_t'($urandom);
            phase_pulse(1'b1);
        end
        sdram_busy = 1'b1;
        step;
        repeat (2) phase_pulse(1'b1);
        sdram_busy  = 1'b0;
        loader_fail = 1'b1;
        repeat (2) phase_pulse(1'b1);
        loader_fail = 1'b0;
        step;
        repeat (2) phase_pulse(1'b0);   // rise phase never reads rom
        rom_ce_n = 1'b1;
        end_test;

        begin_test("wram");
        wram_ce_n = 1'b0;
        wram_rd_n = 1'b0;
        repeat (4) begin
            wram_addr = 17'($urandom);
            phase_pulse(1'b1);
        end
        wram_rd_n = 1'b1;
        wram_we_n = 1'b0;
        repeat (4) begin
            wram_addr = 17'($urandom);
            wram_d    = 8'($urandom);
            phase_pulse(1'b0);
        end
        repeat (2) phase_pulse(1'b1);   // write on fall phase is dropped
        wram_we_n = 1'b1;
        wram_ce_n = 1'b1;
        end_test;

        begin_test("priority");
        rom_ce_n = 1'b0;
        rom_addr = snes_mem_pkg::snes_addr_t'($urandom);
        loading  = 1'b1;
        exp_addr = '0;
        sysclkf_ce = 1'b1;
        step;
        sysclkf_ce = 1'b0;
        load_valid = 1'b1;    // meets f2 in the same cycle
        load_data  = 8'($urandom);
        step;
        load_valid = 1'b0;
        step;
        loading  = 1'b0;
        rom_ce_n = 1'b1;
        end_test;

        begin_test("bsram");
        bsram_ce_n    = 1'b0;
        bsram_rd_n    = 1'b0;
        rom_type      = 8'h20;
        repeat (2) begin
            bsram_addr_in = 20'($urandom);   // fresh address and data per access
            bsram_d       = 8'($urandom);
            phase_pulse(1'b1);
        end
        bsram_rd_n = 1'b1;
        phase_pulse(1'b1);
        rom_type = 8'hC0;     // reads without a read strobe
        repeat (2) phase_pulse(1'b1);
        rom_type = 8'h35;
        phase_pulse(1'b1);
        bsram_we_n = 1'b0;
        repeat (2) begin
            bsram_addr_in = 20'($urandom);
            bsram_d       = 8'($urandom);
            phase_pulse(1'b0);
        end
        phase_pulse(1'b1);
        {bsram_ce_n, bsram_we_n} = 2'b11;
        end_test;

        begin_test("lanes");
        repeat (24) begin
            cpu_port0 = 16'($urandom);
            cpu_port1 = 16'($urandom);
            rom_addr  = snes_mem_pkg::snes_addr_t'($urandom);
            rom_word  = 1'($urandom);
            wram_addr = 17'($urandom);
            aram_addr = 16'($urandom);
            aram_d    = 8'($urandom);
            aram_dout = 16'($urandom);
            aram_ce_n = 1'($urandom);
            case ($urandom % 3)
                0: {aram_oe_n, aram_we_n} = 2'b01;
                1: {aram_oe_n, aram_we_n} = 2'b10;
                default: {aram_oe_n, aram_we_n} = 2'b11;
            endcase
            step;
        end
        {aram_ce_n, aram_oe_n, aram_we_n} = 3'b111;
        end_test;

        $display("tests ok %0d, failed %0d, errors %0d", tests_ok, tests_bad, errors);
        if (tests_bad == 0 && errors == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

endmodule

//--- logic/bus_cycle_phase.sv
////////////////////////////////////////////////////////////////////////////
// run gating for the console core and the registered bus phase strobes
// f2/r2 feed the request arbiter, one cycle after the core's ce pulses
////////////////////////////////////////////////////////////////////////////

module bus_cycle_phase (
    input  logic wclk,
    input  logic resetn,
    input  logic sdram_busy,    // controller still initializing
    input  logic loader_fail,
    input  logic frame_pause,   // video asks for frame sync
    input  logic sysclkf_ce,    // fall phase from core
    input  logic sysclkr_ce,    // rise phase from core
    output logic enable,
    output logic f2,
    output logic r2
);

    logic run_ok;

    // core may only run when nothing holds it back
    assign run_ok = ~sdram_busy & ~loader_fail & ~frame_pause;

    always_ff @(posedge wclk) begin
        if (!resetn) begin
            enable <= 1'b0;
            f2     <= 1'b0;
            r2     <= 1'b0;
        end else begin
            enable <= run_ok;
            f2     <= sysclkf_ce & enable;   // phase only counts while running
            r2     <= sysclkr_ce & enable;
        end
    end

    // a paused core must not issue a phase on the next cycle
    a_no_phase_when_stopped : assert property (
        @(posedge wclk) disable iff (!resetn)
        !enable |=> !(f2 || r2)
    ) else $error("phase strobe after enable was low");

endmodule

//--- logic/load_addr_counter.sv
////////////////////////////////////////////////////////////////////////////
// byte address for cartridge loading, restarts when loading begins
////////////////////////////////////////////////////////////////////////////

module load_addr_counter (
    input  logic                       wclk,
    input  logic                       resetn,
    input  logic                       loading,
    input  logic                       load_valid,   // one byte per pulse
    output snes_mem_pkg::snes_addr_t   load_addr
);

    logic loading_r;   // last cycle's loading, for edge detect

    always_ff @(posedge wclk) begin
        if (!resetn) begin
            loading_r <= 1'b0;
            load_addr <= '0;
        end else begin
            loading_r <= loading;
            if (loading && !loading_r)
                load_addr <= '0;                  // new load, restart at 0
            else if (load_valid)
                load_addr <= load_addr + 1'b1;    // byte taken at the old value
        end
    end

    // first byte of any load lands at address zero
    a_restart_at_zero : assert property (
        @(posedge wclk) disable iff (!resetn)
        $rose(loading) |=> (load_addr == '0)
    ) else $error("load address not cleared at start of loading");

endmodule

//--- logic/mem_lane_steer.sv
////////////////////////////////////////////////////////////////////////////
// byte lane handling between the 8-bit console buses and 16-bit ports
// read data back to the core, ARAM strobes and write data out
////////////////////////////////////////////////////////////////////////////

`include "snes_mem_macros.svh"

module mem_lane_steer (
    input  logic                        wclk,
    input  logic                        resetn,
    input  snes_mem_pkg::mem_word_t     cpu_port0,      // rom data
    input  snes_mem_pkg::mem_word_t     cpu_port1,      // wram data
    input  logic                        rom_addr_lsb,
    input  logic                        rom_word,       // core wants 16 bits
    input  logic                        wram_addr_lsb,
    input  logic [`ARAM_ADDR_W-1:0]     aram_addr,
    input  logic                        aram_ce_n,
    input  logic                        aram_oe_n,
    input  logic                        aram_we_n,
    input  snes_mem_pkg::mem_byte_t     aram_d,
    input  snes_mem_pkg::mem_word_t     aram_dout,
    output snes_mem_pkg::mem_word_t     rom_q,
    output snes_mem_pkg::mem_byte_t     wram_q,
    output snes_mem_pkg::mem_byte_t     aram_q,
    output logic                        aram_rd,
    output logic                        aram_wr,
    output snes_mem_pkg::mem_word_t     aram_din
);

    logic aram_lsb;   // which byte the last aram read wanted

    // odd byte reads come back swapped
    assign rom_q  = (rom_word || !rom_addr_lsb) ? cpu_port0
                                                : {cpu_port0[7:0], cpu_port0[15:8]};
    assign wram_q = wram_addr_lsb ? cpu_port1[15:8] : cpu_port1[7:0];

    assign aram_rd  = ~aram_ce_n & ~aram_oe_n;
    assign aram_wr  = ~aram_ce_n & ~aram_we_n;
    assign aram_din = {aram_d, aram_d};   // ds picks the lane downstream

    // data arrives after the read, so hold the lane bit
    always_ff @(posedge wclk) begin
        if (!resetn)
            aram_lsb <= 1'b0;
        else if (aram_rd)
            aram_lsb <= aram_addr[0];
    end

    assign aram_q = aram_lsb ? aram_dout[15:8] : aram_dout[7:0];

    a_aram_rd_wr_exclusive : assert property (
        @(posedge wclk) disable iff (!resetn)
        !(aram_rd && aram_wr)
    ) else $error("aram read and write together");

endmodule

//--- logic/sdram_req_arbiter.sv
////////////////////////////////////////////////////////////////////////////
// picks one request per cycle for the SDRAM cpu port and registers it
// also registers the BSRAM strobes; loader > rom > wram
////////////////////////////////////////////////////////////////////////////

`include "snes_mem_macros.svh"

module sdram_req_arbiter (
    input  logic                        wclk,
    input  logic                        resetn,
    input  logic                        enable,
    input  logic                        f2,
    input  logic                        r2,
    input  logic                        loading,
    input  logic                        load_valid,
    input  snes_mem_pkg::mem_byte_t     load_data,
    input  snes_mem_pkg::snes_addr_t    load_addr,
    input  snes_mem_pkg::snes_addr_t    rom_addr,
    input  logic                        rom_ce_n,
    input  logic [`WRAM_ADDR_W-1:0]     wram_addr,
    input  snes_mem_pkg::mem_byte_t     wram_d,
    input  logic                        wram_ce_n,
    input  logic                        wram_rd_n,
    input  logic                        wram_we_n,
    input  snes_mem_pkg::mem_byte_t     rom_type,
    input  logic [`BSRAM_ADDR_W-1:0]    bsram_addr_in,
    input  snes_mem_pkg::mem_byte_t     bsram_d,
    input  logic                        bsram_ce_n,
    input  logic                        bsram_rd_n,
    input  logic                        bsram_we_n,
    output logic [`SNES_ADDR_W-2:0]     cpu_word_addr,   // 16-bit word address
    output snes_mem_pkg::mem_word_t     cpu_din,
    output logic [1:0]                  cpu_ds,          // {hi, lo} byte select
    output logic                        cpu_port,        // 0 rom, 1 wram
    output logic                        cpu_rd,
    output logic                        cpu_wr,
    output logic [`BSRAM_ADDR_W-1:0]    bsram_addr,
    output snes_mem_pkg::mem_byte_t     bsram_din,
    output logic                        bsram_rd,
    output logic                        bsram_wr
);

    snes_mem_pkg::req_src_e   src;
    snes_mem_pkg::req_src_e   src_q;      // winner of the registered request
    snes_mem_pkg::snes_addr_t wram_full;  // wram mapped into sdram space
    logic wram_rd;
    logic wram_wr;
    logic bsram_rd_ok;

    assign wram_rd   = ~wram_ce_n & ~wram_rd_n;
    assign wram_wr   = ~wram_ce_n & ~wram_we_n;
    assign wram_full = {`WRAM_BANK_TAG, wram_addr};   // EE,EF:0000-FFFF

    // some map types read bsram without a read strobe
    assign bsram_rd_ok = ~bsram_rd_n | (rom_type[7:4] == `ROM_TYPE_BSRD);

    always_comb begin
        if (loading && load_valid)
            src = snes_mem_pkg::src_load;
        else if (!rom_ce_n && f2)
            src = snes_mem_pkg::src_rom;   // rom only on fall phase
        else if (wram_rd || wram_wr)
            src = snes_mem_pkg::src_wram;
        else
            src = snes_mem_pkg::src_none;
    end

    // strobes
    always_ff @(posedge wclk) begin
        if (!resetn) begin
            cpu_rd   <= 1'b0;
            cpu_wr   <= 1'b0;
            src_q    <= snes_mem_pkg::src_none;
            bsram_rd <= 1'b0;
            bsram_wr <= 1'b0;
        end else begin
            cpu_rd   <= (src == snes_mem_pkg::src_rom) ||
                        (src == snes_mem_pkg::src_wram && wram_rd && f2);
            cpu_wr   <= (src == snes_mem_pkg::src_load) ||
                        (src == snes_mem_pkg::src_wram && wram_wr && r2);
            src_q    <= src;
            bsram_rd <= ~bsram_ce_n & bsram_rd_ok & f2;
            bsram_wr <= ~bsram_ce_n & ~bsram_we_n & r2;
        end
    end

    // request payload, zero when idle
    always_ff @(posedge wclk) begin
        cpu_word_addr <= '0;
        cpu_din       <= '0;
        cpu_ds        <= 2'b00;
        cpu_port      <= 1'b0;
        case (src)
            snes_mem_pkg::src_load: begin
                cpu_word_addr <= load_addr[`SNES_ADDR_W-1:1];
                cpu_din       <= {load_data, load_data};        // same byte both lanes
                cpu_ds        <= {load_addr[0], ~load_addr[0]};
            end
            snes_mem_pkg::src_rom: begin
                cpu_word_addr <= rom_addr[`SNES_ADDR_W-1:1];
                cpu_ds        <= 2'b11;                         // whole word
            end
            snes_mem_pkg::src_wram: begin
                cpu_word_addr <= wram_full[`SNES_ADDR_W-1:1];
                cpu_din       <= {wram_d, wram_d};
                cpu_ds        <= {wram_addr[0], ~wram_addr[0]};
                cpu_port      <= 1'b1;
            end
            default: ;
        endcase
        bsram_addr <= bsram_addr_in;
        bsram_din  <= bsram_d;
    end

    a_rd_wr_exclusive : assert property (
        @(posedge wclk) disable iff (!resetn)
        !(cpu_rd && cpu_wr)
    ) else $error("cpu_rd and cpu_wr together");

    // loader writes use the counter value of the byte's own cycle
    a_load_wr_in_loading : assert property (
        @(posedge wclk) disable iff (!resetn)
        (cpu_wr && src_q == snes_mem_pkg::src_load) |->
            ($past(loading) && cpu_word_addr == $past(load_addr[`SNES_ADDR_W-1:1]))
    ) else $error("loader write outside loading or at wrong address");

    // phase-gated reads trace back to a running core
    a_rd_needs_enable : assert property (
        @(posedge wclk) disable iff (!resetn)
        cpu_rd |-> $past(enable, 2)
    ) else $error("cpu_rd without enable two cycles before");

endmodule

//--- logic/snes_mem_macros.svh
////////////////////////////////////////////////////////////////////////////
// widths and fixed constants of the SNES memory request front end
// include wherever an address width or a fixed code is needed
////////////////////////////////////////////////////////////////////////////

`ifndef SNES_MEM_MACROS_SVH
`define SNES_MEM_MACROS_SVH

// byte address width of the whole SDRAM space
`define SNES_ADDR_W 24

// WRAM is 128 KB
`define WRAM_ADDR_W 17

// upper 7 address bits, puts WRAM at banks EE-EF
`define WRAM_BANK_TAG 7'b1110_111

`define BSRAM_ADDR_W 20
`define ARAM_ADDR_W 16

// rom_type high nibble where BSRAM reads skip bsram_rd_n
`define ROM_TYPE_BSRD 4'hC

`endif

//--- logic/snes_mem_pkg.sv
////////////////////////////////////////////////////////////////////////////
// shared types of the memory front end
// referenced by scoped name, e.g. snes_mem_pkg::snes_addr_t
////////////////////////////////////////////////////////////////////////////

`include "snes_mem_macros.svh"

package snes_mem_pkg;

    // byte address into SDRAM
    typedef logic [`SNES_ADDR_W-1:0] snes_addr_t;

    typedef logic [7:0]  mem_byte_t;   // console side data
    typedef logic [15:0] mem_word_t;   // sdram port data

    // who owns the cpu port this cycle
    typedef enum logic [1:0] {
        src_none = 2'd0,
        src_load = 2'd1,   // cartridge loader write
        src_rom  = 2'd2,   // rom read, fall phase
        src_wram = 2'd3    // wram read or write
    } req_src_e;

endpackage

//--- logic/snes_mem_top.sv
////////////////////////////////////////////////////////////////////////////
// memory request front end between the console core and SDRAM controller
// wiring of phase gen, load counter, arbiter and lane steering
////////////////////////////////////////////////////////////////////////////

`include "snes_mem_macros.svh"

module snes_mem_top (
    input  logic                        wclk,
    input  logic                        resetn,
    input  logic                        sdram_busy,
    input  logic                        loader_fail,
    input  logic                        frame_pause,
    input  logic                        sysclkf_ce,
    input  logic                        sysclkr_ce,
    input  logic                        loading,
    input  logic                        load_valid,
    input  snes_mem_pkg::mem_byte_t     load_data,
    input  snes_mem_pkg::snes_addr_t    rom_addr,
    input  logic                        rom_ce_n,
    input  logic                        rom_word,
    input  logic [`WRAM_ADDR_W-1:0]     wram_addr,
    input  snes_mem_pkg::mem_byte_t     wram_d,
    input  logic                        wram_ce_n,
    input  logic                        wram_rd_n,
    input  logic                        wram_we_n,
    input  snes_mem_pkg::mem_byte_t     rom_type,
    input  logic [`BSRAM_ADDR_W-1:0]    bsram_addr_in,
    input  snes_mem_pkg::mem_byte_t     bsram_d,
    input  logic                        bsram_ce_n,
    input  logic                        bsram_rd_n,
    input  logic                        bsram_we_n,
    input  snes_mem_pkg::mem_word_t     cpu_port0,
    input  snes_mem_pkg::mem_word_t     cpu_port1,
    input  logic [`ARAM_ADDR_W-1:0]     aram_addr,
    input  logic                        aram_ce_n,
    input  logic                        aram_oe_n,
    input  logic                        aram_we_n,
    input  snes_mem_pkg::mem_byte_t     aram_d,
    input  snes_mem_pkg::mem_word_t     aram_dout,
    output logic [`SNES_ADDR_W-2:0]     cpu_word_addr,
    output snes_mem_pkg::mem_word_t     cpu_din,
    output logic [1:0]                  cpu_ds,
    output logic                        cpu_port,
    output logic                        cpu_rd,
    output logic                        cpu_wr,
    output logic [`BSRAM_ADDR_W-1:0]    bsram_addr,
    output snes_mem_pkg::mem_byte_t     bsram_din,
    output logic                        bsram_rd,
    output logic                        bsram_wr,
    output snes_mem_pkg::mem_word_t     rom_q,
    output snes_mem_pkg::mem_byte_t     wram_q,
    output snes_mem_pkg::mem_byte_t     aram_q,
    output logic                        aram_rd,
    output logic                        aram_wr,
    output snes_mem_pkg::mem_word_t     aram_din
);

    logic enable;
    logic f2;
    logic r2;
    snes_mem_pkg::snes_addr_t load_addr;

    bus_cycle_phase u_phase (
        .wclk        (wclk),
        .resetn      (resetn),
        .sdram_busy  (sdram_busy),
        .loader_fail (loader_fail),
        .frame_pause (frame_pause),
        .sysclkf_ce  (sysclkf_ce),
        .sysclkr_ce  (sysclkr_ce),
        .enable      (enable),
        .f2          (f2),
        .r2          (r2)
    );

    load_addr_counter u_load_addr (
        .wclk       (wclk),
        .resetn     (resetn),
        .loading    (loading),
        .load_valid (load_valid),
        .load_addr  (load_addr)
    );

    sdram_req_arbiter u_arb (
        .wclk          (wclk),
        .resetn        (resetn),
        .enable        (enable),
        .f2            (f2),
        .r2            (r2),
        .loading       (loading),
        .load_valid    (load_valid),
        .load_data     (load_data),
        .load_addr     (load_addr),
        .rom_addr      (rom_addr),
        .rom_ce_n      (rom_ce_n),
        .wram_addr     (wram_addr),
        .wram_d        (wram_d),
        .wram_ce_n     (wram_ce_n),
        .wram_rd_n     (wram_rd_n),
        .wram_we_n     (wram_we_n),
        .rom_type      (rom_type),
        .bsram_addr_in (bsram_addr_in),
        .bsram_d       (bsram_d),
        .bsram_ce_n    (bsram_ce_n),
        .bsram_rd_n    (bsram_rd_n),
        .bsram_we_n    (bsram_we_n),
        .cpu_word_addr (cpu_word_addr),
        .cpu_din       (cpu_din),
        .cpu_ds        (cpu_ds),
        .cpu_port      (cpu_port),
        .cpu_rd        (cpu_rd),
        .cpu_wr        (cpu_wr),
        .bsram_addr    (bsram_addr),
        .bsram_din     (bsram_din),
        .bsram_rd      (bsram_rd),
        .bsram_wr      (bsram_wr)
    );

    mem_lane_steer u_steer (
        .wclk          (wclk),
        .resetn        (resetn),
        .cpu_port0     (cpu_port0),
        .cpu_port1     (cpu_port1),
        .rom_addr_lsb  (rom_addr[0]),
        .rom_word      (rom_word),
        .wram_addr_lsb (wram_addr[0]),
        .aram_addr     (aram_addr),
        .aram_ce_n     (aram_ce_n),
        .aram_oe_n     (aram_oe_n),
        .aram_we_n     (aram_we_n),
        .aram_d        (aram_d),
        .aram_dout     (aram_dout),
        .rom_q         (rom_q),
        .wram_q        (wram_q),
        .aram_q        (aram_q),
        .aram_rd       (aram_rd),
        .aram_wr       (aram_wr),
        .aram_din      (aram_din)
    );

endmodule

//--- run_sim.sh
#!/bin/sh
# build and run the memory front end testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f verilog.f --top-module snes_mem_tb -o snes_mem_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/snes_mem_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulator exited with status $status"
    exit 1
fi

if grep -q "^SIMULATION PASSED$" sim.log; then
    exit 0
fi
echo "run did not pass, see sim.log"
exit 1

//--- verilog.f
+incdir+logic
logic/snes_mem_pkg.sv
logic/bus_cycle_phase.sv
logic/load_addr_counter.sv
logic/sdram_req_arbiter.sv
logic/mem_lane_steer.sv
logic/snes_mem_top.sv
bench/snes_mem_tb.sv
